// ==== list.f ====
+incdir+include
design/branch_pkg.sv
design/fetch_pkg.sv
design/pc_generator.sv
design/branch_predictor.sv
design/branch_predecode.sv
design/multi_queue.sv
design/instr_fetch.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// ==== tests/fetch_tb.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module fetch_tb;
	import branch_pkg::*;

	localparam int STEPS = 1380;

	logic              clk = 1'b0;
	logic              rst_n_i;
	logic              flush_i;
	logic              except_valid_i;
	virt_t             except_vec_i;
	branch_resolved_t  resolved_i;
	logic [63:0]       imem_data_i;
	logic [1:0]        credit_return_i;
	logic              imem_req_o;
	virt_t             imem_addr_o;
	logic [1:0]        fetch_valid_o;
	virt_t [1:0]       fetch_vaddr_o;
	logic [1:0][31:0]  fetch_instr_o;
	logic [1:0]        fetch_pred_taken_o;
	virt_t [1:0]       fetch_pred_target_o;
	logic              withhold;
	logic [2:0]        test_id;
	int                outstanding;
	virt_t             last_addr;
	int                chk_errors;
	logic              chk_done;
	logic              chk_timeout;
	virt_t             cf_pc [5] = '{32'hbfc00010, 32'hbfc0001c, 32'hbfc00024,
		32'hbfc00044, 32'hbfc00058};

	always #5 clk = ~clk;

	instr_fetch dut (.*);

	fetch_checker #(.LIMIT(40 * STEPS)) chk (
		.clk, .rst_n_i,
		.imem_req_i(imem_req_o), .imem_addr_i(imem_addr_o),
		.fetch_valid_i(fetch_valid_o), .fetch_vaddr_i(fetch_vaddr_o),
		.fetch_instr_i(fetch_instr_o), .fetch_pred_taken_i(fetch_pred_taken_o),
		.fetch_pred_target_i(fetch_pred_target_o),
		.flush_i, .except_valid_i, .except_vec_i, .resolved_i, .credit_return_i,
		.withhold_i(withhold), .test_id_i(test_id),
		.error_count_o(chk_errors), .done_o(chk_done), .timeout_o(chk_timeout)
	);

	// branch and jump words at a few addresses, addiu everywhere else
	function automatic logic [31:0] mem_word(input virt_t a);
		case (a)
			32'hbfc00010: return 32'h10220004;
			32'hbfc0001c: return 32'h08000010;
			32'hbfc00024: return 32'h03e00008;
			32'hbfc00044: return 32'h14430003;
			32'hbfc00058: return 32'h04210002;
			default:      return {6'b001001, a[27:2] ^ {22'd0, a[31:28]}};
		endcase
	endfunction

	// memory answers one cycle after the request
	always @(negedge clk) begin
		last_addr = imem_addr_o;
		outstanding += int'(fetch_valid_o[0]) + int'(fetch_valid_o[1]);
	end

	always @(posedge clk) begin
		#1 imem_data_i = {mem_word(last_addr + 32'd4), mem_word(last_addr)};
	end

	always @(posedge clk) begin
		if (chk_timeout) begin
			$display("timeout: no finish within %0d cycles", 40 * STEPS);
			$display("test failed");
			$finish;
		end
	end

	task automatic drive_step(input int p_flush, input int p_exc, input int p_res,
		input bit give, input bit train);
		int ret;
		@(posedge clk);
		#1;
		flush_i        = ($urandom % 100) < p_flush;
		except_valid_i = ($urandom % 100) < p_exc;
		except_vec_i   = 32'hbfc00000 + (($urandom % 64) << 2);
		resolved_i     = '0;
		if (($urandom % 100) < p_res) begin
			resolved_i.valid      = 1'b1;
			resolved_i.pc         = (($urandom % 5) == 0 && !train) ?
				32'hbfc00000 + (($urandom % 32) << 2) : cf_pc[$urandom % 5];
			resolved_i.taken      = train ? 1'b1 : 1'($urandom);
			resolved_i.mispredict = train ? 1'b1 : 1'($urandom);
			resolved_i.target     = 32'hbfc00000 + (($urandom % 64) << 2);
			resolved_i.cf         = CF_BRANCH;
		end
		ret = give ? int'($urandom % 3) : 0;
		if (ret > outstanding) ret = outstanding;
		outstanding    -= ret;
		credit_return_i = 2'(ret);
		withhold        = !give;
	endtask

	// handshake at the end of a phase
	task automatic wait_delivery();
		do drive_step(0, 0, 0, 1'b1, 1'b0); while (fetch_valid_o == '0);
	endtask

	initial begin
		void'($urandom(32'h463ff21a));
		rst_n_i         = 1'b0;
		flush_i         = 1'b0;
		except_valid_i  = 1'b0;
		except_vec_i    = '0;
		resolved_i      = '0;
		imem_data_i     = '0;
		credit_return_i = '0;
		withhold        = 1'b0;
		test_id         = 3'd0;
		outstanding     = 0;
		repeat (10) @(posedge clk);
		#1 rst_n_i = 1'b1;

		repeat (200) drive_step(0, 0, 0, 1'b1, 1'b0);
		wait_delivery();
		test_id = 3'd1;
		repeat (300) drive_step(2, 2, 4, 1'b1, 1'b0);
		wait_delivery();
		test_id = 3'd2;
		repeat (300) drive_step(1, 0, 6, 1'b1, 1'b1);
		wait_delivery();
		test_id = 3'd3;
		repeat (40) drive_step(0, 0, 0, 1'b1, 1'b0);
		repeat (80) drive_step(0, 0, 0, 1'b0, 1'b0);
		repeat (30) drive_step(0, 0, 0, 1'b1, 1'b0);
		wait_delivery();
		test_id = 3'd4;
		repeat (430) drive_step(1, 1, 3, 1'b1, 1'b0);
		wait_delivery();
		test_id = 3'd5;
		while (!chk_done) drive_step(0, 0, 0, 1'b1, 1'b0);
		if (chk_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fetch_checker.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module fetch_checker #(
	parameter int LIMIT = 1000
) (
	input  wire                                clk,
	input  wire                                rst_n_i,
	input  wire                                imem_req_i,
	input  wire branch_pkg::virt_t             imem_addr_i,
	input  wire [1:0]                          fetch_valid_i,
	input  wire branch_pkg::virt_t [1:0]       fetch_vaddr_i,
	input  wire [1:0][31:0]                    fetch_instr_i,
	input  wire [1:0]                          fetch_pred_taken_i,
	input  wire branch_pkg::virt_t [1:0]       fetch_pred_target_i,
	input  wire                                flush_i,
	input  wire                                except_valid_i,
	input  wire branch_pkg::virt_t             except_vec_i,
	input  wire branch_pkg::branch_resolved_t  resolved_i,
	input  wire [1:0]                          credit_return_i,
	input  wire                                withhold_i,
	input  wire [2:0]                          test_id_i,
	output int                                 error_count_o,
	output logic                               done_o,
	output logic                               timeout_o
);
	import branch_pkg::*;

	// btb model, armed once a redirect guarantees a fresh lookup
	typedef struct {
		logic  valid;
		logic  taken;
		logic  armed;
		virt_t pc;
		virt_t target;
	} line_t;

	line_t      btb [`BTB_ENTRIES];
	virt_t      expect_pc;
	virt_t      req_pc;
	logic       redir_q;
	int         credits;
	int         stall_base;
	int         stall_cnt;
	int         checks;
	int         test_errors;
	int         cycles;
	logic [2:0] cur_test;
	logic       hold_q;

	// same table as the memory model in fetch_tb
	function automatic logic [31:0] mem_word(input virt_t a);
		case (a)
			32'hbfc00010: return 32'h10220004;
			32'hbfc0001c: return 32'h08000010;
			32'hbfc00024: return 32'h03e00008;
			32'hbfc00044: return 32'h14430003;
			32'hbfc00058: return 32'h04210002;
			default:      return {6'b001001, a[27:2] ^ {22'd0, a[31:28]}};
		endcase
	endfunction

	function automatic logic is_cf(input virt_t a);
		logic [31:0] w;
		w = mem_word(a);
		return w[31:26] != 6'b001001;
	endfunction

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0:    return "sequential";
			3'd1:    return "redirects";
			3'd2:    return "btb_training";
			3'd3:    return "credit_stall";
			default: return "random_mix";
		endcase
	endfunction

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("** Error %s: %s expected %h actual %h", test_name(cur_test), what, exp, act);
		error_count_o++;
		test_errors++;
	endtask

	task automatic report_fault(input string what);
		$display("%s: %s", test_name(cur_test), what);
		error_count_o++;
		test_errors++;
	endtask

	always @(negedge clk) begin
		virt_t v;
		line_t l;
		int    n;
		logic  redir;
		if (!rst_n_i) begin
			foreach (btb[i]) btb[i] = '{1'b0, 1'b0, 1'b0, '0, '0};
			expect_pc     = `RESET_VECTOR;
			req_pc        = `RESET_VECTOR;
			redir_q       = 1'b0;
			credits       = `FETCH_CREDITS;
			error_count_o = 0;
			test_errors   = 0;
			checks        = 0;
			cycles        = 0;
			cur_test      = 3'd0;
			hold_q        = 1'b0;
			done_o        = 1'b0;
			timeout_o     = 1'b0;
			if (imem_req_i || fetch_valid_i != '0) begin
				report_fault("fetch request or delivery while in reset");
			end
		end else begin
			cycles++;
			if (cycles >= LIMIT) timeout_o = 1'b1;
			redir = flush_i || except_valid_i || (resolved_i.valid && resolved_i.mispredict);

			if (imem_req_i && imem_addr_i[2:0] != 3'b000) begin
				report_fault($sformatf("fetch address %h is not pair aligned", imem_addr_i));
			end
			// the redirect target is requested in the very next cycle
			if (redir_q && !redir) begin
				if (!imem_req_i) begin
					report_fault("no fetch request in the cycle after a redirect");
				end else if (imem_addr_i != {req_pc[31:3], 3'b000}) begin
					mismatch("imem_addr", {req_pc[31:3], 3'b000}, imem_addr_i);
				end
			end

			n = 0;
			for (int i = 0; i < 2; i++) begin
				if (fetch_valid_i[i]) begin
					v = fetch_vaddr_i[i];
					n++;
					checks++;
					if (v != expect_pc) mismatch("vaddr", expect_pc, v);
					if (fetch_instr_i[i] != mem_word(v)) begin
						mismatch("instr", mem_word(v), fetch_instr_i[i]);
					end
					if (fetch_pred_taken_i[i] && !is_cf(v)) begin
						report_fault($sformatf("taken prediction on a plain instruction at %h",
							v));
					end
					l = btb[v[6:3]];
					if (l.valid && l.armed && l.taken && l.pc == v && is_cf(v)) begin
						if (!fetch_pred_taken_i[i]) mismatch("pred_taken", 1, 0);
						else if (fetch_pred_target_i[i] != l.target) begin
							mismatch("pred_target", l.target, fetch_pred_target_i[i]);
						end
					end
					expect_pc = fetch_pred_taken_i[i] ? fetch_pred_target_i[i] : v + 32'd4;
				end
			end
			if (n > credits) mismatch("delivered", credits, n);
			// with returns withheld, exactly the credits held get through
			if (withhold_i) begin
				if (!hold_q) begin
					stall_base = credits;
					stall_cnt  = 0;
				end
				stall_cnt += n;
			end else if (hold_q && stall_cnt != stall_base) begin
				mismatch("stall_count", stall_base, stall_cnt);
			end
			hold_q  = withhold_i;
			credits = credits - n + int'(credit_return_i);

			if (resolved_i.valid) begin
				btb[resolved_i.pc[6:3]] = '{1'b1, resolved_i.taken, 1'b0, resolved_i.pc,
					resolved_i.target};
			end
			if (redir) begin
				foreach (btb[i]) btb[i].armed = btb[i].valid;
				if (except_valid_i) expect_pc = except_vec_i;
				else if (resolved_i.valid && resolved_i.mispredict) expect_pc = resolved_i.target;
				else expect_pc = `RESET_VECTOR;
				req_pc = expect_pc;
			end
			redir_q = redir;

			if (test_id_i != cur_test) begin
				$display("%-13s %s, %0d errors", test_name(cur_test),
					test_errors == 0 ? "ok" : "FAIL", test_errors);
				test_errors = 0;
				cur_test    = test_id_i;
				if (test_id_i == 3'd5) begin
					$display("entries checked %0d, errors %0d, cycles %0d",
						checks, error_count_o, cycles);
					done_o = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/instr_fetch.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module instr_fetch (
	input  wire                               clk,
	input  wire                               rst_n_i,
	input  wire                               flush_i,
	input  wire                               except_valid_i,
	input  wire branch_pkg::virt_t            except_vec_i,
	input  wire branch_pkg::branch_resolved_t resolved_i,
	input  wire [32*`FETCH_NUM-1:0]           imem_data_i,
	input  wire [1:0]                         credit_return_i,
	output logic                              imem_req_o,
	output branch_pkg::virt_t                 imem_addr_o,
	output logic [`FETCH_NUM-1:0]             fetch_valid_o,
	output branch_pkg::virt_t [`FETCH_NUM-1:0] fetch_vaddr_o,
	output logic [`FETCH_NUM-1:0][31:0]       fetch_instr_o,
	output logic [`FETCH_NUM-1:0]             fetch_pred_taken_o,
	output branch_pkg::virt_t [`FETCH_NUM-1:0] fetch_pred_target_o
);
	import branch_pkg::*;
	import fetch_pkg::*;

	localparam int CW = `CREDIT_WIDTH;

	logic                      ext_redirect;
	virt_t                     ext_pc;
	logic                      kill_s1;
	logic                      kill_s2;
	virt_t                     pc_s1;
	logic                      pc_valid_s1;
	logic                      s2_valid_q;
	virt_t                     s2_pc_q;
	branch_predict_t           bp_s2;
	logic                      predict_fire;
	fetch_group_t              raw_s2;
	fetch_group_t              s2_group;
	fetch_group_t              s3_group_q;
	fetch_group_t              push_group;
	cf_kind_t [`FETCH_NUM-1:0] kind_s3;
	logic [`FETCH_NUM-1:0]     bad_taken;
	presolved_t                presolve;
	logic                      presolve_fire;
	logic                      replay_fire;
	fetch_cnt_t                push_num;
	logic                      queue_full;
	fetch_group_t              pop_group;
	logic [`FETCH_NUM-1:0]     pop_valid;
	fetch_cnt_t                pop_avail;
	fetch_cnt_t                pop_num;
	logic [CW-1:0]             credits_q;

	// exception first, then mispredict, a lone flush restarts
	always_comb begin
		ext_redirect = flush_i | except_valid_i | (resolved_i.valid & resolved_i.mispredict);
		if (except_valid_i) begin
			ext_pc = except_vec_i;
		end else if (resolved_i.valid && resolved_i.mispredict) begin
			ext_pc = resolved_i.target;
		end else begin
			ext_pc = `RESET_VECTOR;
		end
	end

	assign kill_s2 = ext_redirect | presolve_fire | replay_fire;
	assign kill_s1 = kill_s2 | predict_fire;

	pc_generator u_pc_gen (
		.clk,
		.rst_n_i,
		.redirect_i    (ext_redirect | presolve_fire),
		.redirect_pc_i (ext_redirect ? ext_pc : presolve.target),
		.predict_i     (predict_fire),
		.predict_pc_i  (bp_s2.target),
		.replay_i      (replay_fire),
		.replay_pc_i   (s3_group_q[0].vaddr),
		.pc_o          (pc_s1),
		.pc_valid_o    (pc_valid_s1)
	);

	assign imem_req_o  = pc_valid_s1 & ~kill_s1;
	assign imem_addr_o = group_base(pc_s1);

	// table read skipped when nothing is requested
	branch_predictor u_bpu (
		.clk,
		.rst_n_i,
		.lookup_pc_i (pc_s1),
		.hold_i      (~imem_req_o),
		.update_i    (resolved_i),
		.predict_o   (bp_s2)
	);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			s2_valid_q <= 1'b0;
		end else begin
			s2_valid_q <= imem_req_o;
		end
	end

	always_ff @(posedge clk) begin
		s2_pc_q <= pc_s1;
	end

	assign predict_fire = s2_valid_q & bp_s2.valid & bp_s2.taken;

	always_comb begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			raw_s2[i].vaddr      = group_base(s2_pc_q) + 32'(4 * i);
			raw_s2[i].instr      = imem_data_i[32*i +: 32];
			raw_s2[i].pred       = bp_s2;
			raw_s2[i].pred.valid = bp_s2.valid && (int'(bp_s2.slot) == i);
		end
		raw_s2[0].valid = s2_valid_q & ~slot_of(s2_pc_q);
		// nothing behind a taken slot 0
		raw_s2[1].valid = s2_valid_q & ~(bp_s2.valid & bp_s2.taken & ~bp_s2.slot);

		// first fetched word always lands in entry 0
		if (raw_s2[0].valid) begin
			s2_group = raw_s2;
		end else begin
			s2_group[0]       = raw_s2[1];
			s2_group[1]       = raw_s2[1];
			s2_group[1].valid = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || kill_s2) begin
			for (int i = 0; i < `FETCH_NUM; i++) begin
				s3_group_q[i].valid <= 1'b0;
			end
		end else begin
			s3_group_q <= s2_group;
		end
	end

	for (genvar i = 0; i < `FETCH_NUM; i++) begin : g_predecode
		branch_predecode u_predecode (
			.instr_i (s3_group_q[i].instr),
			.kind_o  (kind_s3[i]),
			.imm_o   ()
		);
	end

	// drop predictions on plain instructions, refetch after a taken one
	always_comb begin
		push_group = s3_group_q;
		for (int i = 0; i < `FETCH_NUM; i++) begin
			bad_taken[i] = s3_group_q[i].valid & s3_group_q[i].pred.valid &
				s3_group_q[i].pred.taken & (kind_s3[i] == CF_NONE);
			if (s3_group_q[i].valid && s3_group_q[i].pred.valid && kind_s3[i] == CF_NONE) begin
				push_group[i].pred.valid = 1'b0;
				push_group[i].pred.taken = 1'b0;
			end
		end
		presolve.mispredict = |bad_taken;
		presolve.pc         = bad_taken[0] ? s3_group_q[0].vaddr : s3_group_q[1].vaddr;
		presolve.target     = presolve.pc + 32'd4;
	end

	// no room for the group, fetch it again
	assign replay_fire   = s3_group_q[0].valid & queue_full;
	assign presolve_fire = presolve.mispredict & ~replay_fire;
	assign push_num      = (ext_redirect || replay_fire) ? '0 :
		fetch_cnt_t'(s3_group_q[0].valid) + fetch_cnt_t'(s3_group_q[1].valid);

	multi_queue #(
		.dtype (fetch_entry_t)
	) u_iq (
		.clk,
		.rst_n_i,
		.flush_i     (ext_redirect),
		.push_num_i  (push_num),
		.push_data_i (push_group),
		.pop_num_i   (pop_num),
		.full_o      (queue_full),
		.pop_data_o  (pop_group),
		.pop_valid_o (pop_valid)
	);

	// deliver what is queued, bounded by credits held
	assign pop_avail = fetch_cnt_t'(pop_valid[0]) + fetch_cnt_t'(pop_valid[1]);
	assign pop_num   = (CW'(pop_avail) <= credits_q) ? pop_avail : fetch_cnt_t'(credits_q);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			credits_q <= CW'(`FETCH_CREDITS);
		end else begin
			credits_q <= credits_q - CW'(pop_num) + CW'(credit_return_i);
		end
	end

	always_comb begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			fetch_valid_o[i]       = i < int'(pop_num);
			fetch_vaddr_o[i]       = pop_group[i].vaddr;
			fetch_instr_o[i]       = pop_group[i].instr;
			fetch_pred_taken_o[i]  = pop_group[i].pred.valid & pop_group[i].pred.taken;
			fetch_pred_target_o[i] = pop_group[i].pred.target;
		end
	end

	credits_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		credits_q <= CW'(`FETCH_CREDITS));

endmodule

`default_nettype wire

// ==== design/multi_queue.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module multi_queue #(
	parameter type dtype   = fetch_pkg::fetch_entry_t,
	parameter int  CHANNEL = `IQ_CHANNEL,
	parameter int  DEPTH   = `IQ_DEPTH
) (
	input  wire                        clk,
	input  wire                        rst_n_i,
	input  wire                        flush_i,
	input  wire fetch_pkg::fetch_cnt_t push_num_i,
	input  wire dtype                  push_data_i [`FETCH_NUM],
	input  wire fetch_pkg::fetch_cnt_t pop_num_i,
	output logic                       full_o,
	output dtype                       pop_data_o [`FETCH_NUM],
	output logic [`FETCH_NUM-1:0]      pop_valid_o
);
	localparam int TOTAL = CHANNEL * DEPTH;
	localparam int CW    = $clog2(CHANNEL);
	localparam int PW    = $clog2(TOTAL);
	localparam int NW    = $clog2(TOTAL + 1);

	// one bank per channel, consecutive entries go to consecutive banks
	dtype          mem [CHANNEL][DEPTH];
	logic [PW-1:0] wr_ptr_q;
	logic [PW-1:0] rd_ptr_q;
	logic [NW-1:0] count_q;
	logic [PW-1:0] wr_addr [`FETCH_NUM];
	logic [PW-1:0] rd_addr [`FETCH_NUM];

	always_comb begin
		for (int k = 0; k < `FETCH_NUM; k++) begin
			wr_addr[k] = wr_ptr_q + PW'(k);
			rd_addr[k] = rd_ptr_q + PW'(k);
		end
	end

	// low pointer bits pick the bank, high bits the row
	always_ff @(posedge clk) begin
		for (int k = 0; k < `FETCH_NUM; k++) begin
			if (k < int'(push_num_i)) begin
				mem[wr_addr[k][CW-1:0]][wr_addr[k][PW-1:CW]] <= push_data_i[k];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			wr_ptr_q <= wr_ptr_q + PW'(push_num_i);
			rd_ptr_q <= rd_ptr_q + PW'(pop_num_i);
			count_q  <= count_q + NW'(push_num_i) - NW'(pop_num_i);
		end
	end

	always_comb begin
		for (int k = 0; k < `FETCH_NUM; k++) begin
			pop_data_o[k]  = mem[rd_addr[k][CW-1:0]][rd_addr[k][PW-1:CW]];
			pop_valid_o[k] = count_q > NW'(k);
		end
	end

	// full leaves no room for a whole group
	assign full_o = (NW'(TOTAL) - count_q) < NW'(`FETCH_NUM);

	pop_within_count: assert property (@(posedge clk) disable iff (!rst_n_i)
		NW'(pop_num_i) <= count_q);

	no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
		push_num_i != '0 |-> !full_o);

endmodule

`default_nettype wire

// ==== design/branch_predecode.sv ====
`default_nettype none

module branch_predecode (
	input  wire [31:0]           instr_i,
	output branch_pkg::cf_kind_t kind_o,
	output branch_pkg::virt_t    imm_o
);
	import branch_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rt;
	virt_t      branch_offset;
	virt_t      jump_index;

	assign opcode = instr_i[31:26];
	assign funct  = instr_i[5:0];
	assign rt     = instr_i[20:16];
	// word offset, sign extended
	assign branch_offset = {{14{instr_i[15]}}, instr_i[15:0], 2'b00};
	// low 28 bits of a j/jal target
	assign jump_index    = {4'b0000, instr_i[25:0], 2'b00};

	always_comb begin
		kind_o = CF_NONE;
		imm_o  = '0;
		case (opcode)
			6'b000100, 6'b000101, 6'b000110, 6'b000111: begin
				kind_o = CF_BRANCH;
				imm_o  = branch_offset;
			end
			// regimm: bltz, bgez, bltzal, bgezal
			6'b000001: begin
				if (rt inside {5'b00000, 5'b00001, 5'b10000, 5'b10001}) begin
					kind_o = CF_BRANCH;
					imm_o  = branch_offset;
				end
			end
			6'b000010, 6'b000011: begin
				kind_o = CF_JUMP;
				imm_o  = jump_index;
			end
			// jr and jalr take the target from a register
			6'b000000: begin
				if (funct == 6'b001000 || funct == 6'b001001) begin
					kind_o = CF_JUMP;
				end
			end
			default: begin
				kind_o = CF_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/branch_predictor.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module branch_predictor (
	input  wire                               clk,
	input  wire                               rst_n_i,
	input  wire branch_pkg::virt_t            lookup_pc_i,
	input  wire                               hold_i,
	input  wire branch_pkg::branch_resolved_t update_i,
	output branch_pkg::branch_predict_t       predict_o
);
	import branch_pkg::*;
	import fetch_pkg::*;

	localparam int IDX_W   = $clog2(`BTB_ENTRIES);
	localparam int TAG_LSB = 3 + IDX_W;

	typedef struct packed {
		logic [31:TAG_LSB] tag;
		virt_t             target;
		cf_kind_t          kind;
		logic              slot;
		logic              taken;
	} btb_line_t;

	btb_line_t               btb_mem [`BTB_ENTRIES];
	logic [`BTB_ENTRIES-1:0] btb_valid_q;
	logic [IDX_W-1:0]        lookup_idx;
	logic [IDX_W-1:0]        update_idx;
	btb_line_t               lookup_line;
	logic                    lookup_hit;
	branch_predict_t         lookup_result;

	assign lookup_idx  = lookup_pc_i[TAG_LSB-1:3];
	assign update_idx  = update_i.pc[TAG_LSB-1:3];
	assign lookup_line = btb_mem[lookup_idx];
	assign lookup_hit  = btb_valid_q[lookup_idx] &&
		(lookup_line.tag == lookup_pc_i[31:TAG_LSB]);

	always_comb begin
		lookup_result.valid  = lookup_hit;
		// a branch behind the fetch pc in the pair is not ours to follow
		lookup_result.taken  = lookup_hit && lookup_line.taken &&
			(lookup_line.slot >= slot_of(lookup_pc_i));
		lookup_result.target = lookup_line.target;
		lookup_result.cf     = lookup_line.kind;
		lookup_result.slot   = lookup_line.slot;
	end

	// result lines up with s2
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			predict_o <= '0;
		end else if (!hold_i) begin
			predict_o <= lookup_result;
		end
	end

	always_ff @(posedge clk) begin
		if (update_i.valid) begin
			btb_mem[update_idx].tag    <= update_i.pc[31:TAG_LSB];
			btb_mem[update_idx].target <= update_i.target;
			btb_mem[update_idx].kind   <= update_i.cf;
			btb_mem[update_idx].slot   <= slot_of(update_i.pc);
			btb_mem[update_idx].taken  <= update_i.taken;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			btb_valid_q <= '0;
		end else if (update_i.valid) begin
			btb_valid_q[update_idx] <= 1'b1;
		end
	end

	same_index_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		(update_i.valid && !hold_i && update_idx == lookup_idx) |->
		!$isunknown({update_i.pc, lookup_pc_i}));

endmodule

`default_nettype wire

// ==== design/pc_generator.sv ====
`include "fetch_cfg.svh"
`default_nettype none

module pc_generator (
	input  wire                    clk,
	input  wire                    rst_n_i,
	input  wire                    redirect_i,
	input  wire branch_pkg::virt_t redirect_pc_i,
	input  wire                    predict_i,
	input  wire branch_pkg::virt_t predict_pc_i,
	input  wire                    replay_i,
	input  wire branch_pkg::virt_t replay_pc_i,
	output branch_pkg::virt_t      pc_o,
	output logic                   pc_valid_o
);
	import branch_pkg::*;
	import fetch_pkg::*;

	virt_t pc_d;

	// redirect beats replay, replay beats the btb
	always_comb begin
		if (redirect_i) begin
			pc_d = redirect_pc_i;
		end else if (replay_i) begin
			pc_d = replay_pc_i;
		end else if (predict_i) begin
			pc_d = predict_pc_i;
		end else begin
			pc_d = group_base(pc_o) + 32'd8;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_o       <= `RESET_VECTOR;
			pc_valid_o <= 1'b0;
		end else begin
			pc_valid_o <= 1'b1;
			// first valid cycle fetches the reset vector itself
			if (pc_valid_o || redirect_i) begin
				pc_o <= pc_d;
			end
		end
	end

	pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		pc_valid_o |-> pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`include "fetch_cfg.svh"
`default_nettype none

package fetch_pkg;

	localparam int GROUP_ALIGN = $clog2(`FETCH_NUM) + 2;

	// one queued instruction
	typedef struct packed {
		logic                        valid;
		branch_pkg::virt_t           vaddr;
		logic [31:0]                 instr;
		branch_pkg::branch_predict_t pred;
	} fetch_entry_t;

	// entries of one fetch group, slot 0 first
	typedef fetch_entry_t fetch_group_t [`FETCH_NUM];

	// entry count for push and pop, 0 to 2
	typedef logic [1:0] fetch_cnt_t;

	// address of the aligned pair holding pc
	function automatic branch_pkg::virt_t group_base(input branch_pkg::virt_t pc);
		return {pc[31:GROUP_ALIGN], {GROUP_ALIGN{1'b0}}};
	endfunction

	// word position of pc inside its pair
	function automatic logic slot_of(input branch_pkg::virt_t pc);
		return pc[2];
	endfunction

endpackage

`default_nettype wire

// ==== design/branch_pkg.sv ====
`default_nettype none

package branch_pkg;

	typedef logic [31:0] virt_t;

	// control-flow kind as seen by the predecoder and the back end
	typedef enum logic [1:0] {
		CF_NONE   = 2'd0,
		CF_BRANCH = 2'd1,
		CF_JUMP   = 2'd2
	} cf_kind_t;

	// btb prediction for one fetch group
	typedef struct packed {
		logic     valid;
		logic     taken;
		virt_t    target;
		cf_kind_t cf;
		// which word of the pair the prediction sits on
		logic     slot;
	} branch_predict_t;

	// resolution reported by the back end
	typedef struct packed {
		logic     valid;
		logic     mispredict;
		logic     taken;
		virt_t    pc;
		virt_t    target;
		cf_kind_t cf;
	} branch_resolved_t;

	// correction raised by the front end itself
	typedef struct packed {
		logic  mispredict;
		virt_t pc;
		virt_t target;
	} presolved_t;

endpackage

`default_nettype wire

// ==== include/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// instructions per fetch group and per output cycle
`define FETCH_NUM 2

// instruction queue shape
`define IQ_DEPTH 4
`define IQ_CHANNEL 4

// btb lines, indexed by pc[6:3]
`define BTB_ENTRIES 16

// first fetch address after reset or flush
`define RESET_VECTOR 32'hbfc00000

// credits granted by the back end, and the counter width
`define FETCH_CREDITS 6
`define CREDIT_WIDTH 3

`endif
